/* percFormatPkg.sv */
package percFormatPkg;

	//////////////////////////////
	// Word and vector sizes
	//////////////////////////////

	localparam int WORD_W = 16;     // Q-format data word
	localparam int LWORD_W = 32;    // Accumulator word
	localparam int LPC_M = 10;      // LSF order
	localparam int N_SUB = 2;       // Subframes per frame

	//////////////////////////////
	// Datapath types
	//////////////////////////////

	typedef logic signed [WORD_W-1:0] wordT;

	// Index 0 is the first reflection coefficient
	typedef wordT [1:0] rcPairT;

	typedef wordT [LPC_M-1:0] lsfVecT;       // One LSF vector
	typedef lsfVecT [N_SUB-1:0] lsfSetT;     // One vector per lane
	typedef wordT [N_SUB-1:0] gammaPairT;    // One factor per subframe

endpackage

/* percTuningPkg.sv */
package percTuningPkg;

	//////////////////////////////
	// LAR approximation
	//////////////////////////////

	localparam percFormatPkg::wordT SEG1 = 16'sd1299;     // Linear segment limit
	localparam percFormatPkg::wordT SEG2 = 16'sd1815;
	localparam percFormatPkg::wordT SEG3 = 16'sd1944;

	localparam percFormatPkg::wordT A1 = 16'sd4567;       // Segment slopes
	localparam percFormatPkg::wordT A2 = 16'sd11776;
	localparam percFormatPkg::wordT A3 = 16'sd27443;

	localparam logic signed [percFormatPkg::LWORD_W-1:0] L_B1 = 32'sd3271557;
	localparam logic signed [percFormatPkg::LWORD_W-1:0] L_B2 = 32'sd16357786;
	localparam logic signed [percFormatPkg::LWORD_W-1:0] L_B3 = 32'sd46808433;

	localparam int LAR_SHIFT = 11;

	//////////////////////////////
	// Smoothing hysteresis
	//////////////////////////////

	localparam percFormatPkg::wordT THRESH_L1 = -16'sd3562;  // Turn-off pair
	localparam percFormatPkg::wordT THRESH_H1 = 16'sd1336;
	localparam percFormatPkg::wordT THRESH_L2 = -16'sd3116;  // Turn-on pair
	localparam percFormatPkg::wordT THRESH_H2 = 16'sd890;

	//////////////////////////////
	// Bandwidth expansion factors
	//////////////////////////////

	localparam percFormatPkg::wordT GAMMA1_0 = 16'sd32113;
	localparam percFormatPkg::wordT GAMMA1_1 = 16'sd30802;
	localparam percFormatPkg::wordT GAMMA2_0_H = 16'sd22938;   // Clamp limits
	localparam percFormatPkg::wordT GAMMA2_0_L = 16'sd13107;
	localparam percFormatPkg::wordT GAMMA2_1 = 16'sd19661;

	localparam percFormatPkg::wordT ALPHA = 16'sd19302;    // Slope of gamma2 line
	localparam percFormatPkg::wordT BETA = 16'sd1024;      // Intercept of gamma2 line
	localparam int GAMMA2_SHIFT = 5;

endpackage

/* larSmoothing.sv */
`timescale 1ns/1ps

module larSmoothing
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic done,
	input percFormatPkg::rcPairT rc,
	input percFormatPkg::lsfVecT lsfInt,
	input percFormatPkg::lsfVecT lsfNew,
	output logic busy,
	output logic laneLoad,
	output percFormatPkg::lsfSetT laneLsf,
	output logic [percFormatPkg::N_SUB-1:0] smoothFlags
);
	import percFormatPkg::*;
	import percTuningPkg::*;

	rcPairT rcQ;
	lsfVecT lsfIntQ;
	lsfVecT lsfNewQ;
	wordT [1:0] larNew;
	wordT [1:0] larOld;
	wordT [1:0] larInt;
	logic busyQ;
	logic [1:0] step;       // 1 converts, 2 interpolates, 3 loads lanes
	logic smooth;           // Carries across subframes and frames
	logic flagSub0;
	logic flagSub1;
	logic accept;

	function automatic wordT sat16(input logic signed [LWORD_W-1:0] x);
		if (x > 32'sd32767)
			sat16 = 16'sh7FFF;
		else if (x < -32'sd32768)
			sat16 = 16'sh8000;
		else
			sat16 = x[WORD_W-1:0];
	endfunction

	// Three-segment approximation of the log-area ratio
	function automatic wordT rcToLar(input wordT rcIn);
		logic signed [LWORD_W-1:0] wide;
		logic signed [LWORD_W-1:0] offset;
		logic signed [LWORD_W-1:0] lTemp;
		wordT curRc;
		wordT slope;
		wordT lar;
		wide = LWORD_W'(rcIn);
		if (wide < 0)
			wide = -wide;
		curRc = sat16(wide) >>> 4;
		slope = A3;
		offset = L_B3;
		if (curRc <= SEG1)
			lar = curRc;                    // Linear part
		else
		begin
			if (curRc <= SEG2)
			begin
				slope = A1;
				offset = L_B1;
			end
			else if (curRc <= SEG3)
			begin
				slope = A2;
				offset = L_B2;
			end
			curRc = curRc >>> 1;
			lTemp = (LWORD_W'(curRc) * LWORD_W'(slope)) <<< 1;
			lTemp = (lTemp - offset) >>> LAR_SHIFT;
			lar = lTemp[WORD_W-1:0];
		end
		if (rcIn < 0)
			lar = sat16(-LWORD_W'(lar));    // Restore sign
		rcToLar = lar;
	endfunction

	function automatic logic nextSmooth(input logic cur, input wordT crit0, input wordT crit1);
		if (cur)
			nextSmooth = !((crit0 < THRESH_L1) && (crit1 > THRESH_H1));
		else
			nextSmooth = (crit0 > THRESH_L2) || (crit1 < THRESH_H2);
	endfunction

	assign busy = busyQ && !done;      // Falls in the done cycle
	assign accept = start && !busy;
	assign laneLsf[0] = lsfIntQ;
	assign laneLsf[1] = lsfNewQ;

	always_comb
	begin
		for (int i = 0; i < 2; i++)
			larInt[i] = sat16(LWORD_W'(larNew[i]) + LWORD_W'(larOld[i])) >>> 1;
		flagSub0 = nextSmooth(smooth, larInt[0], larInt[1]);     // Subframe 0 on averages
		flagSub1 = nextSmooth(flagSub0, larNew[0], larNew[1]);   // Subframe 1 on new LARs
	end

	//////////////////////////////
	// Sequence and persistent state
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busyQ <= 1'b0;
			step <= 2'd0;
			laneLoad <= 1'b0;
			smooth <= 1'b1;
			smoothFlags <= '1;
			larOld <= '0;
		end
		else
		begin
			laneLoad <= 1'b0;
			if (accept)
				busyQ <= 1'b1;
			else if (done)
				busyQ <= 1'b0;
			case (step)
				2'd1: step <= 2'd2;
				2'd2:
				begin
					larOld <= larNew;
					smooth <= flagSub1;
					smoothFlags <= {flagSub1, flagSub0};
					step <= 2'd3;
				end
				2'd3:
				begin
					laneLoad <= 1'b1;
					step <= 2'd0;
				end
				default:
				begin
					if (accept)
						step <= 2'd1;       // New frame
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			rcQ <= rc;
			lsfIntQ <= lsfInt;
			lsfNewQ <= lsfNew;
		end
		if (step == 2'd1)
		begin
			for (int i = 0; i < 2; i++)
				larNew[i] <= rcToLar(rcQ[i]);
		end
	end

endmodule

/* spacingGamma.sv */
`timescale 1ns/1ps

module spacingGamma
(
	input logic clk,
	input logic reset,
	input logic load,
	input percFormatPkg::lsfVecT lsf,
	output percFormatPkg::wordT gamma2,
	output logic valid
);
	import percFormatPkg::*;
	import percTuningPkg::*;

	lsfVecT lsfQ;               // Doubled LSFs
	logic [3:0] idx;
	logic running;
	logic finish;
	wordT dMin;
	wordT diff;
	wordT gammaRaw;
	wordT gammaClamp;

	function automatic wordT sat16(input logic signed [LWORD_W-1:0] x);
		if (x > 32'sd32767)
			sat16 = 16'sh7FFF;
		else if (x < -32'sd32768)
			sat16 = 16'sh8000;
		else
			sat16 = x[WORD_W-1:0];
	endfunction

	//////////////////////////////
	// Spacing and gamma2 line
	//////////////////////////////

	always_comb
	begin
		diff = sat16(LWORD_W'(lsfQ[idx]) - LWORD_W'(lsfQ[idx - 4'd1]));
		gammaRaw = sat16((LWORD_W'(ALPHA) * LWORD_W'(dMin)) >>> 15);       // Q15 product
		gammaRaw = sat16(LWORD_W'(BETA) - LWORD_W'(gammaRaw));
		gammaRaw = sat16(LWORD_W'(gammaRaw) <<< GAMMA2_SHIFT);
		if (gammaRaw > GAMMA2_0_H)
			gammaClamp = GAMMA2_0_H;
		else if (gammaRaw < GAMMA2_0_L)
			gammaClamp = GAMMA2_0_L;
		else
			gammaClamp = gammaRaw;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			idx <= 4'd1;
			running <= 1'b0;
			finish <= 1'b0;
			valid <= 1'b0;
		end
		else
		begin
			valid <= finish;
			finish <= running && (idx == LPC_M - 1);
			if (load)
			begin
				idx <= 4'd1;
				running <= 1'b1;
			end
			else if (running)
			begin
				if (idx == LPC_M - 1)
					running <= 1'b0;
				else
					idx <= idx + 4'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			for (int k = 0; k < LPC_M; k++)
				lsfQ[k] <= sat16(LWORD_W'(lsf[k]) <<< 1);
			dMin <= 16'sh7FFF;          // First difference always wins
		end
		else if (running && (diff < dMin))
			dMin <= diff;
		if (finish)
			gamma2 <= gammaClamp;
	end

endmodule

/* gammaSelect.sv */
`timescale 1ns/1ps

module gammaSelect
(
	input logic clk,
	input logic reset,
	input logic [percFormatPkg::N_SUB-1:0] smoothFlags,
	input percFormatPkg::gammaPairT laneGamma2,
	input logic [percFormatPkg::N_SUB-1:0] laneValid,
	output percFormatPkg::gammaPairT gamma1,
	output percFormatPkg::gammaPairT gamma2,
	output logic done
);
	import percFormatPkg::*;
	import percTuningPkg::*;

	logic allValid;
	gammaPairT gamma1Next;
	gammaPairT gamma2Next;

	assign allValid = &laneValid;

	always_comb
	begin
		for (int k = 0; k < N_SUB; k++)
		begin
			if (smoothFlags[k])
			begin
				gamma1Next[k] = GAMMA1_1;       // Smooth spectrum
				gamma2Next[k] = GAMMA2_1;
			end
			else
			begin
				gamma1Next[k] = GAMMA1_0;
				gamma2Next[k] = laneGamma2[k];  // Adapted from d_min
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gamma1 <= '0;
			gamma2 <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= allValid;
			if (allValid)
			begin
				gamma1 <= gamma1Next;
				gamma2 <= gamma2Next;
			end
		end
	end

endmodule

/* percAdapt.sv */
`timescale 1ns/1ps

module percAdapt
(
	input logic clk,
	input logic reset,
	input logic start,
	input percFormatPkg::rcPairT rc,
	input percFormatPkg::lsfVecT lsfInt,
	input percFormatPkg::lsfVecT lsfNew,
	output logic busy,
	output logic done,
	output percFormatPkg::gammaPairT gamma1,
	output percFormatPkg::gammaPairT gamma2
);
	import percFormatPkg::*;

	logic laneLoad;
	lsfSetT laneLsf;
	logic [N_SUB-1:0] smoothFlags;
	gammaPairT laneGamma2;
	logic [N_SUB-1:0] laneValid;

	larSmoothing feeder
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.done(done),
		.rc(rc),
		.lsfInt(lsfInt),
		.lsfNew(lsfNew),
		.busy(busy),
		.laneLoad(laneLoad),
		.laneLsf(laneLsf),
		.smoothFlags(smoothFlags)
	);

	//////////////////////////////
	// One lane per subframe
	//////////////////////////////

	for (genvar k = 0; k < N_SUB; k++)
	begin : gLane
		spacingGamma lane
		(
			.clk(clk),
			.reset(reset),
			.load(laneLoad),
			.lsf(laneLsf[k]),
			.gamma2(laneGamma2[k]),
			.valid(laneValid[k])
		);
	end

	gammaSelect drain
	(
		.clk(clk),
		.reset(reset),
		.smoothFlags(smoothFlags),
		.laneGamma2(laneGamma2),
		.laneValid(laneValid),
		.gamma1(gamma1),
		.gamma2(gamma2),
		.done(done)
	);

endmodule

/* percAdapt_tb.sv */
`timescale 1ns/1ps

module percAdapt_tb;
	import percFormatPkg::*;

	localparam int FIELDS = 26;             // 2 rc, 2x10 LSF, 4 gammas
	localparam int DONE_TIMEOUT = 40;
	localparam int DONE_LATENCY = 15;
	localparam int SECOND_START_FRAME = 4;  // Gets an extra start while busy
	localparam int QUIET_CYCLES = 20;

	logic clk;
	logic reset;
	logic start;
	rcPairT rc;
	lsfVecT lsfInt;
	lsfVecT lsfNew;
	logic busy;
	logic done;
	gammaPairT gamma1;
	gammaPairT gamma2;

	logic [FIELDS*WORD_W-1:0] rows[$];    // One golden frame per entry
	logic frameOk;
	int checks;
	int valueErrors;
	int otherErrors;

	percAdapt dut0
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.rc(rc),
		.lsfInt(lsfInt),
		.lsfNew(lsfNew),
		.busy(busy),
		.done(done),
		.gamma1(gamma1),
		.gamma2(gamma2)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			valueErrors++;
			$display("ERR time %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			valueErrors++;
			$display("ERR time %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		checks++;
		assert (got == exp)
		else
		begin
			valueErrors++;
			$display("ERR time %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkIdle();
		checkBit("busy", busy, 1'b0);
		checkBit("done", done, 1'b0);
		checkWord("gamma1[0]", gamma1[0], 16'h0000);
		checkWord("gamma1[1]", gamma1[1], 16'h0000);
		checkWord("gamma2[0]", gamma2[0], 16'h0000);
		checkWord("gamma2[1]", gamma2[1], 16'h0000);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic clearInputs();
		start = 1'b0;
		rc = '0;
		lsfInt = '0;
		lsfNew = '0;
	endtask

	task automatic loadGolden();
		int fd;
		int n;
		string line;
		logic [WORD_W-1:0] fld [0:FIELDS-1];
		logic [FIELDS*WORD_W-1:0] row;
		fd = $fopen("percAdaptGolden.txt", "r");
		if (fd == 0)
		begin
			otherErrors++;
			$display("Could not open the golden file percAdaptGolden.txt");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if ((n == 0) || (line.len() < 2) || (line.substr(0, 1) == "//"))
				continue;                   // Blank or comment line
			n = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
				fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
				fld[17], fld[18], fld[19], fld[20], fld[21], fld[22], fld[23], fld[24],
				fld[25]);
			if (n != FIELDS)
			begin
				otherErrors++;
				$display("Golden line has %0d fields instead of %0d: %s", n, FIELDS, line);
			end
			else
			begin
				for (int k = 0; k < FIELDS; k++)
					row[k*WORD_W +: WORD_W] = fld[k];
				rows.push_back(row);
			end
		end
		$fclose(fd);
	endtask

	task automatic runFrame(input int idx, input logic secondStart, output logic ok);
		logic [FIELDS*WORD_W-1:0] row;
		int cycles;
		logic seen;
		row = rows[idx];
		seen = 1'b0;
		@(posedge clk);
		#1;
		start = 1'b1;
		rc[0] = row[0 +: WORD_W];
		rc[1] = row[WORD_W +: WORD_W];
		for (int k = 0; k < LPC_M; k++)
		begin
			lsfInt[k] = row[(2 + k)*WORD_W +: WORD_W];
			lsfNew[k] = row[(2 + LPC_M + k)*WORD_W +: WORD_W];
		end
		@(posedge clk);                     // E0
		#1;
		clearInputs();
		checkBit("busy", busy, 1'b1);
		checkBit("done", done, 1'b0);
		cycles = 0;
		while ((cycles < DONE_TIMEOUT) && !seen)
		begin
			@(posedge clk);
			cycles++;
			#1;
			if (done === 1'b1)
				seen = 1'b1;
			else
				checkBit("busy", busy, 1'b1);
			if (secondStart && (cycles == 5))
			begin
				start = 1'b1;               // Must be ignored
				rc = {16'h8000, 16'h8000};
				lsfNew = '1;
			end
			else if (secondStart && (cycles == 6))
				clearInputs();
		end
		clearInputs();
		ok = seen;
		if (!seen)
		begin
			otherErrors++;
			$display("Frame %0d timed out: no done within %0d cycles of start", idx, DONE_TIMEOUT);
			return;
		end
		checkCount("done latency", cycles, DONE_LATENCY);
		checkBit("busy", busy, 1'b0);
		checkWord("gamma1[0]", gamma1[0], row[22*WORD_W +: WORD_W]);
		checkWord("gamma1[1]", gamma1[1], row[23*WORD_W +: WORD_W]);
		checkWord("gamma2[0]", gamma2[0], row[24*WORD_W +: WORD_W]);
		checkWord("gamma2[1]", gamma2[1], row[25*WORD_W +: WORD_W]);
	endtask

	// A spurious second frame would show up as another done
	task automatic watchNoDone(input int cyclesToWatch);
		for (int c = 0; c < cyclesToWatch; c++)
		begin
			@(posedge clk);
			#1;
			checkBit("done", done, 1'b0);
			checkBit("busy", busy, 1'b0);
		end
	endtask

	initial
	begin
		checks = 0;
		valueErrors = 0;
		otherErrors = 0;
		reset = 1'b1;
		clearInputs();
		loadGolden();
		for (int c = 0; c < 10; c++)
		begin
			@(posedge clk);
			#1;
			checkIdle();
		end
		reset = 1'b0;
		for (int c = 0; c < 3; c++)
		begin
			@(posedge clk);
			#1;
			checkIdle();
		end
		if (rows.size() <= SECOND_START_FRAME)
		begin
			otherErrors++;
			$display("Golden file holds only %0d frames", rows.size());
		end
		for (int i = 0; i < rows.size(); i++)
		begin
			runFrame(i, i == SECOND_START_FRAME, frameOk);
			if (!frameOk)
				break;                      // Timed out
			if (i == SECOND_START_FRAME)
				watchNoDone(QUIET_CYCLES);
		end
		$display("Checks %0d, value errors %0d, other failures %0d",
			checks, valueErrors, otherErrors);
		if ((valueErrors == 0) && (otherErrors == 0))
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* percAdaptGolden.txt */
// Columns: rc0 rc1, lsfInt[0..9], lsfNew[0..9], then gamma1[0] gamma1[1] gamma2[0] gamma2[1]
// All words are 16-bit hex; frames run in order since LAR history and smoothing carry over
4000 1000 0300 0700 0B00 0F00 1300 1700 1B00 1F00 2300 2700 0280 0680 0A80 0E80 1280 1680 1A80 1E80 2280 2680 7852 7852 4CCD 4CCD
8000 6000 0300 0700 0B00 0F00 1300 1700 1B00 1F00 2300 2700 0400 0C00 1400 1C00 2400 2C00 3400 3C00 4000 4800 7852 7D71 4CCD 599A
8400 7800 0400 0800 0D00 1200 1700 1C00 2100 2600 2B00 3000 0200 0600 0A00 0E00 0F80 1380 1780 1B80 1F80 2380 7D71 7D71 3333 4780
0800 F000 0300 0700 0B00 0F00 1300 1700 1B00 1F00 2300 2700 0280 0680 0A80 0E80 1280 1680 1A80 1E80 2280 2680 7852 7852 4CCD 4CCD
9000 7FFF 0300 0700 0B00 0F00 1300 1700 1B00 1F00 2300 2700 0280 0680 0A80 0E80 1280 1680 1A80 1E80 2280 2680 7852 7852 4CCD 4CCD
8000 6000 0300 0700 0B00 0F00 1300 1700 1B00 1F00 2300 2700 0800 0A00 0E00 1200 1600 1A00 1E00 2200 2600 2A00 7852 7D71 4CCD 34A0

/* percAdapt.f */
percFormatPkg.sv
percTuningPkg.sv
larSmoothing.sv
spacingGamma.sv
gammaSelect.sv
percAdapt.sv
percAdapt_tb.sv

/* Bender.yml */
package:
  name: percAdapt

sources:
  - percFormatPkg.sv
  - percTuningPkg.sv
  - larSmoothing.sv
  - spacingGamma.sv
  - gammaSelect.sv
  - percAdapt.sv
  - target: simulation
    files:
      - percAdapt_tb.sv
